/* axi_pkt_pkg.sv */
// AXI write-channel packet definitions
// Data, strobe and id widths
// Burst and response encodings
// AW, W and B packet structs

package axi_pkt_pkg;

  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int ID_WIDTH   = 4;

  // AXI burst encoding, 2'b11 is reserved
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // Write address, 49 bits
  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    logic [2:0]          size;
    logic [7:0]          len;
    burst_e              burst;
    logic [31:0]         addr;
  } aw_pkt_t;

  // Write data beat, 41 bits
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } w_pkt_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    resp_e               resp;
  } b_pkt_t;

endpackage

/* link_pkg.sv */
// Logic link definitions
// PHY receive and transmit words
// Link bring-up states

package link_pkg;

  // Receive word, all kept channels in one beat (93 bits)
  typedef struct packed {
    logic                 aw_push;
    axi_pkt_pkg::aw_pkt_t aw;
    logic                 w_push;
    axi_pkt_pkg::w_pkt_t  w;
    logic                 b_credit;
  } rx_word_t;

  // Transmit word (9 bits)
  typedef struct packed {
    logic                b_push;
    axi_pkt_pkg::b_pkt_t b;
    logic                aw_credit;
    logic                w_credit;
  } tx_word_t;

  typedef enum logic [1:0] {
    LINK_OFFLINE = 2'b00,
    LINK_WAIT    = 2'b01,
    LINK_ONLINE  = 2'b10
  } link_state_e;

endpackage

/* link_online_sync.sv */
// Link bring-up qualification
// Both online levels must hold for ONLINE_DELAY cycles

`timescale 1ns/1ps

module link_online_sync #(
  parameter int ONLINE_DELAY = 4
) (
  input  logic clk_wr,
  input  logic rst,
  input  logic tx_online,
  input  logic rx_online,
  output logic link_up
);

  localparam int CNT_W = $clog2(ONLINE_DELAY + 1);

  link_pkg::link_state_e state;
  logic [CNT_W-1:0]      wait_cnt;
  logic                  both_online;

  assign both_online = tx_online && rx_online;
  assign link_up     = (state == link_pkg::LINK_ONLINE);

  // wait_cnt holds the number of consecutive cycles seen with both inputs high
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      state    <= link_pkg::LINK_OFFLINE;
      wait_cnt <= '0;
    end else begin
      case (state)
        link_pkg::LINK_OFFLINE: begin
          if (both_online) begin
            wait_cnt <= CNT_W'(1);
            if (ONLINE_DELAY <= 1) begin
              state <= link_pkg::LINK_ONLINE;
            end else begin
              state <= link_pkg::LINK_WAIT;
            end
          end
        end
        link_pkg::LINK_WAIT: begin
          if (!both_online) begin
            state    <= link_pkg::LINK_OFFLINE;
            wait_cnt <= '0;
          end else if (wait_cnt >= CNT_W'(ONLINE_DELAY - 1)) begin
            state <= link_pkg::LINK_ONLINE;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        link_pkg::LINK_ONLINE: begin
          // Drop straight away, no hold-off on the way down
          if (!both_online) begin
            state    <= link_pkg::LINK_OFFLINE;
            wait_cnt <= '0;
          end
        end
        default: begin
          state    <= link_pkg::LINK_OFFLINE;
          wait_cnt <= '0;
        end
      endcase
    end
  end

endmodule

/* ll_receive.sv */
// Credit-returning receive FIFO
// Circular buffer with fill count
// One credit pulse per popped entry

`timescale 1ns/1ps

module ll_receive #(
  parameter int WIDTH = $bits(axi_pkt_pkg::aw_pkt_t),
  parameter int DEPTH = 8
) (
  input  logic             clk_wr,
  input  logic             rst,
  input  logic             link_up,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  output logic [WIDTH-1:0] user_data,
  output logic             user_valid,
  input  logic             user_ready,
  output logic             credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic             full;
  logic             wr_en;
  logic             pop;

  // Pointer step with wrap, DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full       = (fill == CNT_W'(DEPTH));
  assign wr_en      = link_up && push && !full;
  assign user_valid = link_up && (fill != '0);
  assign pop        = user_valid && user_ready;
  assign user_data  = mem[rd_ptr];

  // Control state, flushed while the link is down
  always_ff @(posedge clk_wr) begin
    if (rst || !link_up) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
      credit <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_en, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // Freed slot goes back to the far side next cycle
      credit <= pop;
    end
  end

  // Storage
  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

/* ll_transmit.sv */
// Credit-counted transmit stage for B responses
// Registered push toward the link

`timescale 1ns/1ps

module ll_transmit (
  input  logic                clk_wr,
  input  logic                rst,
  input  logic                link_up,
  input  logic [7:0]          init_credit,
  input  axi_pkt_pkg::b_pkt_t user_data,
  input  logic                user_valid,
  output logic                user_ready,
  input  logic                rx_credit,
  output logic                push,
  output axi_pkt_pkg::b_pkt_t push_data
);

  logic [7:0] credit_cnt;
  logic [7:0] credit_nxt;
  logic       take;

  // Only accept while the far side has room
  assign user_ready = link_up && (credit_cnt != 8'd0);
  assign take       = user_valid && user_ready;

  // Returned credit and a spent credit in one cycle cancel out
  always_comb begin
    case ({rx_credit, take})
      2'b10:   credit_nxt = credit_cnt + 8'd1;
      2'b01:   credit_nxt = credit_cnt - 8'd1;
      default: credit_nxt = credit_cnt;
    endcase
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      credit_cnt <= 8'd0;
      push       <= 1'b0;
    end else if (!link_up) begin
      // Far side starts over with its full buffer
      credit_cnt <= init_credit;
      push       <= 1'b0;
    end else begin
      credit_cnt <= credit_nxt;
      push       <= take;
    end
  end

  // Payload follows the accepted transfer
  always_ff @(posedge clk_wr) begin
    if (take) begin
      push_data <= user_data;
    end
  end

endmodule

/* phy_concat.sv */
// PHY word register stage
// Splits the receive word into channel pushes and packets
// Merges B push and channel credits into the transmit word

`timescale 1ns/1ps

module phy_concat (
  input  logic                 clk_wr,
  input  logic                 rst,
  input  logic                 link_up,
  input  link_pkg::rx_word_t   rx_phy,
  output link_pkg::tx_word_t   tx_phy,
  output logic                 aw_push,
  output axi_pkt_pkg::aw_pkt_t aw_data,
  output logic                 w_push,
  output axi_pkt_pkg::w_pkt_t  w_data,
  output logic                 b_credit,
  input  logic                 aw_credit,
  input  logic                 w_credit,
  input  logic                 b_push,
  input  axi_pkt_pkg::b_pkt_t  b_data
);

  logic               aw_push_q;
  logic               w_push_q;
  logic               b_credit_q;
  link_pkg::tx_word_t tx_q;

  //////////////////////////////////////////////////////////////////////
  // Receive direction

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      aw_push_q  <= 1'b0;
      w_push_q   <= 1'b0;
      b_credit_q <= 1'b0;
    end else begin
      aw_push_q  <= rx_phy.aw_push;
      w_push_q   <= rx_phy.w_push;
      b_credit_q <= rx_phy.b_credit;
    end
  end

  always_ff @(posedge clk_wr) begin
    aw_data <= rx_phy.aw;
    w_data  <= rx_phy.w;
  end

  // Nothing from the far side counts before bring-up
  assign aw_push  = aw_push_q && link_up;
  assign w_push   = w_push_q && link_up;
  assign b_credit = b_credit_q && link_up;

  //////////////////////////////////////////////////////////////////////
  // Transmit direction

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_q <= '0;
    end else begin
      tx_q.b_push    <= b_push;
      tx_q.b         <= b_push ? b_data : '0;
      tx_q.aw_credit <= aw_credit;
      tx_q.w_credit  <= w_credit;
    end
  end

  assign tx_phy = link_up ? tx_q : '0;

endmodule

/* axi_pkt_slave_top.sv */
// AXI write-packet slave bridge, top level
// Link bring-up, PHY register stage, AW and W receive FIFOs
// and the credit-counted B transmit path

`timescale 1ns/1ps

module axi_pkt_slave_top #(
  parameter int AW_DEPTH     = 8,
  parameter int W_DEPTH      = 16,
  parameter int ONLINE_DELAY = 4
) (
  input  logic                 clk_wr,
  input  logic                 rst,

  input  logic                 tx_online,
  input  logic                 rx_online,
  input  logic [7:0]           init_b_credit,

  input  link_pkg::rx_word_t   rx_phy,
  output link_pkg::tx_word_t   tx_phy,

  output axi_pkt_pkg::aw_pkt_t user_aw,
  output logic                 user_awvalid,
  input  logic                 user_awready,

  output axi_pkt_pkg::w_pkt_t  user_w,
  output logic                 user_wvalid,
  input  logic                 user_wready,

  input  axi_pkt_pkg::b_pkt_t  user_b,
  input  logic                 user_bvalid,
  output logic                 user_bready
);

  localparam int AW_WIDTH = $bits(axi_pkt_pkg::aw_pkt_t);
  localparam int W_WIDTH  = $bits(axi_pkt_pkg::w_pkt_t);

  logic                 link_up;

  logic                 aw_push;
  axi_pkt_pkg::aw_pkt_t aw_data;
  logic                 aw_credit;
  logic [AW_WIDTH-1:0]  aw_push_word;
  logic [AW_WIDTH-1:0]  aw_pop_word;

  logic                 w_push;
  axi_pkt_pkg::w_pkt_t  w_data;
  logic                 w_credit;
  logic [W_WIDTH-1:0]   w_push_word;
  logic [W_WIDTH-1:0]   w_pop_word;

  logic                 b_credit;
  logic                 b_push;
  axi_pkt_pkg::b_pkt_t  b_data;

  //////////////////////////////////////////////////////////////////////
  // Bring-up and PHY stage

  link_online_sync #(
    .ONLINE_DELAY (ONLINE_DELAY)
  ) online_i (
    .clk_wr    (clk_wr),
    .rst       (rst),
    .tx_online (tx_online),
    .rx_online (rx_online),
    .link_up   (link_up)
  );

  phy_concat phy_i (
    .clk_wr    (clk_wr),
    .rst       (rst),
    .link_up   (link_up),
    .rx_phy    (rx_phy),
    .tx_phy    (tx_phy),
    .aw_push   (aw_push),
    .aw_data   (aw_data),
    .w_push    (w_push),
    .w_data    (w_data),
    .b_credit  (b_credit),
    .aw_credit (aw_credit),
    .w_credit  (w_credit),
    .b_push    (b_push),
    .b_data    (b_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Channel FIFOs and B transmit

  // Struct to flat FIFO word and back
  assign aw_push_word = aw_data;
  assign user_aw      = aw_pop_word;
  assign w_push_word  = w_data;
  assign user_w       = w_pop_word;

  ll_receive #(
    .WIDTH (AW_WIDTH),
    .DEPTH (AW_DEPTH)
  ) aw_rx_i (
    .clk_wr     (clk_wr),
    .rst        (rst),
    .link_up    (link_up),
    .push       (aw_push),
    .push_data  (aw_push_word),
    .user_data  (aw_pop_word),
    .user_valid (user_awvalid),
    .user_ready (user_awready),
    .credit     (aw_credit)
  );

  ll_receive #(
    .WIDTH (W_WIDTH),
    .DEPTH (W_DEPTH)
  ) w_rx_i (
    .clk_wr     (clk_wr),
    .rst        (rst),
    .link_up    (link_up),
    .push       (w_push),
    .push_data  (w_push_word),
    .user_data  (w_pop_word),
    .user_valid (user_wvalid),
    .user_ready (user_wready),
    .credit     (w_credit)
  );

  ll_transmit b_tx_i (
    .clk_wr      (clk_wr),
    .rst         (rst),
    .link_up     (link_up),
    .init_credit (init_b_credit),
    .user_data   (user_b),
    .user_valid  (user_bvalid),
    .user_ready  (user_bready),
    .rx_credit   (b_credit),
    .push        (b_push),
    .push_data   (b_data)
  );

endmodule

/* tb_axi_pkt_slave_props.sv */
// Concurrent checks for the receive FIFOs and the B transmit stage
// Bound into ll_receive and ll_transmit

`timescale 1ns/1ps

module tb_axi_pkt_slave_props #(
  parameter int WIDTH = 8
) (
  input logic             clk_wr,
  input logic             rst,
  input logic             link_up,
  input logic             fifo_push,
  input logic             fifo_full,
  input logic             pop,
  input logic             credit,
  input logic             valid,
  input logic             ready,
  input logic [WIDTH-1:0] data,
  input logic             tx_push,
  input logic [7:0]       init_credit,
  input logic             rx_credit
);

  // Far side buffer space still free, counted from link pushes and returns
  logic [7:0] link_credit;

  always_ff @(posedge clk_wr) begin
    if (rst || !link_up) begin
      link_credit <= init_credit;
    end else begin
      link_credit <= link_credit + {7'd0, rx_credit} - {7'd0, tx_push};
    end
  end

  // Far side only sends what it holds credits for
  no_push_when_full: assert property (@(posedge clk_wr) disable iff (rst)
    fifo_push |-> !fifo_full)
    else $error("push arrived while the receive FIFO was full");

  credit_after_pop: assert property (@(posedge clk_wr) disable iff (rst)
    pop |=> credit)
    else $error("no credit pulse in the cycle after a pop");

  push_needs_credit: assert property (@(posedge clk_wr) disable iff (rst)
    tx_push |-> (link_credit != 8'd0))
    else $error("transmit push sent with no link credit");

  // Payload held while the consumer stalls
  stable_while_stalled: assert property (@(posedge clk_wr) disable iff (rst)
    (valid && !ready) |=> (!valid || $stable(data)))
    else $error("data changed while valid was held without ready");

endmodule

bind ll_receive tb_axi_pkt_slave_props #(.WIDTH(WIDTH)) rx_props_i (
  .clk_wr      (clk_wr),
  .rst         (rst),
  .link_up     (link_up),
  .fifo_push   (push),
  .fifo_full   (full),
  .pop         (pop),
  .credit      (credit),
  .valid       (user_valid),
  .ready       (user_ready),
  .data        (user_data),
  .tx_push     (1'b0),
  .init_credit (8'd0),
  .rx_credit   (1'b0)
);

bind ll_transmit tb_axi_pkt_slave_props #(.WIDTH($bits(axi_pkt_pkg::b_pkt_t))) tx_props_i (
  .clk_wr      (clk_wr),
  .rst         (rst),
  .link_up     (link_up),
  .fifo_push   (1'b0),
  .fifo_full   (1'b0),
  .pop         (1'b0),
  .credit      (1'b0),
  .valid       (user_valid),
  .ready       (user_ready),
  .data        (user_data),
  .tx_push     (push),
  .init_credit (init_credit),
  .rx_credit   (rx_credit)
);

/* tb_axi_pkt_slave.sv */
// Testbench for the AXI write-packet slave bridge
// Table of tests applied in a loop, LFSR payloads,
// tx_phy monitor, watchdog and per-test reporting

`timescale 1ns/1ps

module tb_axi_pkt_slave;

  localparam int AW_DEPTH      = 8;
  localparam int W_DEPTH       = 16;
  localparam int ONLINE_DELAY  = 4;
  localparam int INIT_B_CREDIT = 3;
  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 3;
  localparam int DRAIN_CYCLES  = 150;
  localparam int ROW_CYCLES    = 250;
  localparam int NUM_ROWS      = 7;
  localparam int WATCHDOG_NS   = (RESET_CYCLES + NUM_ROWS * ROW_CYCLES) * CLK_PERIOD;
  localparam int AW_BITS       = $bits(axi_pkt_pkg::aw_pkt_t);
  localparam int W_BITS        = $bits(axi_pkt_pkg::w_pkt_t);
  localparam int B_BITS        = $bits(axi_pkt_pkg::b_pkt_t);

  typedef enum int {CH_IDLE, CH_UP, CH_AW, CH_W, CH_B, CH_DROP} chan_e;
  typedef enum int {READY_HIGH, READY_LFSR} ready_e;

  ////////////////////////////////////////////////////////////////////
  // Test table: name, channel, packets, ready pattern, expected value

  string  row_name  [NUM_ROWS] = '{"reset_idle", "bring_up", "aw_single", "aw_burst",
                                   "w_fill_drain", "b_credit_limit", "rx_offline"};
  chan_e  row_chan  [NUM_ROWS] = '{CH_IDLE, CH_UP, CH_AW, CH_AW, CH_W, CH_B, CH_DROP};
  int     row_count [NUM_ROWS] = '{4, 0, 1, AW_DEPTH, W_DEPTH, INIT_B_CREDIT, 3};
  ready_e row_ready [NUM_ROWS] = '{READY_HIGH, READY_HIGH, READY_HIGH, READY_LFSR,
                                   READY_LFSR, READY_HIGH, READY_HIGH};
  int     row_exp   [NUM_ROWS] = '{0, 1, 1, AW_DEPTH, W_DEPTH, INIT_B_CREDIT + 1, 0};

  logic                 clk_wr = 1'b0;
  logic                 rst;
  logic                 tx_online;
  logic                 rx_online;
  logic [7:0]           init_b_credit;
  link_pkg::rx_word_t   rx_phy;
  link_pkg::tx_word_t   tx_phy;
  axi_pkt_pkg::aw_pkt_t user_aw;
  logic                 user_awvalid;
  logic                 user_awready;
  axi_pkt_pkg::w_pkt_t  user_w;
  logic                 user_wvalid;
  logic                 user_wready;
  axi_pkt_pkg::b_pkt_t  user_b;
  logic                 user_bvalid;
  logic                 user_bready;

  logic [31:0]          lfsr_state = 32'h1a8e;
  int                   cur_row;
  int                   row_errors;
  int                   total_errors;
  int                   tests_passed;
  int                   tests_failed;
  int                   aw_credit_seen;
  int                   w_credit_seen;
  axi_pkt_pkg::b_pkt_t  b_seen [$];

  axi_pkt_slave_top #(
    .AW_DEPTH     (AW_DEPTH),
    .W_DEPTH      (W_DEPTH),
    .ONLINE_DELAY (ONLINE_DELAY)
  ) dut_i (
    .clk_wr        (clk_wr),
    .rst           (rst),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .init_b_credit (init_b_credit),
    .rx_phy        (rx_phy),
    .tx_phy        (tx_phy),
    .user_aw       (user_aw),
    .user_awvalid  (user_awvalid),
    .user_awready  (user_awready),
    .user_w        (user_w),
    .user_wvalid   (user_wvalid),
    .user_wready   (user_wready),
    .user_b        (user_b),
    .user_bvalid   (user_bvalid),
    .user_bready   (user_bready)
  );

  always #(CLK_PERIOD / 2) clk_wr = ~clk_wr;

  // tx_phy monitor, sampled mid-cycle
  always @(negedge clk_wr) begin
    if (tx_phy.aw_credit) aw_credit_seen++;
    if (tx_phy.w_credit) w_credit_seen++;
    if (tx_phy.b_push) b_seen.push_back(tx_phy.b);
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test table finished");
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // Helpers

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[62:0], fb};
    end
    return val;
  endfunction

  function automatic axi_pkt_pkg::aw_pkt_t rand_aw();
    logic [63:0]          bits;
    axi_pkt_pkg::aw_pkt_t p;
    bits    = lfsr_bits(AW_BITS);
    p       = bits[AW_BITS-1:0];
    p.burst = axi_pkt_pkg::INCR;
    return p;
  endfunction

  function automatic axi_pkt_pkg::w_pkt_t rand_w();
    logic [63:0] bits;
    bits = lfsr_bits(W_BITS);
    return bits[W_BITS-1:0];
  endfunction

  function automatic axi_pkt_pkg::b_pkt_t rand_b();
    logic [63:0] bits;
    bits = lfsr_bits(B_BITS);
    return bits[B_BITS-1:0];
  endfunction

  function automatic int credits_seen();
    return (row_chan[cur_row] == CH_AW) ? aw_credit_seen : w_credit_seen;
  endfunction

  function automatic logic rx_valid();
    return (row_chan[cur_row] == CH_AW) ? user_awvalid : user_wvalid;
  endfunction

  function automatic logic [63:0] rx_data();
    return (row_chan[cur_row] == CH_AW) ? 64'(user_aw) : 64'(user_w);
  endfunction

  task automatic set_rx_ready(input logic rdy);
    if (row_chan[cur_row] == CH_AW) user_awready <= rdy;
    else user_wready <= rdy;
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("MISMATCH %s %s: expected %h, actual %h", row_name[cur_row], what, exp_v, act_v);
    row_errors++;
  endtask

  task automatic report_error(input string what);
    $display("ERROR %s: %s", row_name[cur_row], what);
    row_errors++;
  endtask

  // Valids, bready and tx_phy while the link is down
  task automatic check_quiet(input string what);
    if ({user_awvalid, user_wvalid, user_bready} != 3'(row_exp[cur_row])) begin
      report_mismatch({what, " valids"}, 64'(row_exp[cur_row]),
                      64'({user_awvalid, user_wvalid, user_bready}));
    end
    if (tx_phy != '0) report_mismatch({what, " tx_phy"}, 64'd0, 64'(tx_phy));
  endtask

  ////////////////////////////////////////////////////////////////////
  // Test rows

  task automatic run_idle();
    link_pkg::rx_word_t rxw;
    @(negedge clk_wr);
    check_quiet("after reset");
    for (int i = 0; i < row_count[cur_row] + 3; i++) begin
      rxw = '0;
      if (i < row_count[cur_row]) begin
        rxw.aw_push  = 1'b1;
        rxw.aw       = rand_aw();
        rxw.w_push   = 1'b1;
        rxw.w        = rand_w();
        rxw.b_credit = 1'b1;
      end
      @(posedge clk_wr);
      rx_phy <= rxw;
      @(negedge clk_wr);
      check_quiet("link down");
    end
  endtask

  task automatic run_bring_up();
    int waited;
    waited = 0;
    @(posedge clk_wr);
    tx_online <= 1'b1;
    rx_online <= 1'b1;
    do begin
      @(negedge clk_wr);
      waited++;
    end while (!user_bready && waited < ONLINE_DELAY + 3);
    if (user_bready != 1'(row_exp[cur_row])) begin
      report_mismatch("user_bready", 64'(row_exp[cur_row]), 64'(user_bready));
    end
    if (user_awvalid || user_wvalid) report_error("pushes from before bring-up were delivered");
  endtask

  // AW or W: fill with ready low, then drain with the row's ready pattern
  task automatic run_rx_channel();
    logic [63:0]        exp_q [$];
    logic [63:0]        bits;
    link_pkg::rx_word_t rxw;
    logic               rdy;
    int                 base_credits;
    int                 cycles;
    @(posedge clk_wr);
    base_credits = credits_seen();
    for (int i = 0; i < row_count[cur_row]; i++) begin
      rxw = '0;
      if (row_chan[cur_row] == CH_AW) begin
        rxw.aw_push = 1'b1;
        rxw.aw      = rand_aw();
        exp_q.push_back(64'(rxw.aw));
      end else begin
        rxw.w_push = 1'b1;
        rxw.w      = rand_w();
        exp_q.push_back(64'(rxw.w));
      end
      rx_phy <= rxw;
      @(posedge clk_wr);
    end
    rx_phy <= '0;
    repeat (4) @(posedge clk_wr);
    if (credits_seen() != base_credits) report_error("credit returned while ready was low");
    cycles = 0;
    while (exp_q.size() > 0 && cycles < DRAIN_CYCLES) begin
      bits = lfsr_bits(1);
      rdy  = (row_ready[cur_row] == READY_HIGH) ? 1'b1 : bits[0];
      set_rx_ready(rdy);
      @(negedge clk_wr);
      if (rx_valid() && rdy) begin
        if (rx_data() != exp_q[0]) report_mismatch("user data", exp_q[0], rx_data());
        void'(exp_q.pop_front());
      end
      @(posedge clk_wr);
      cycles++;
    end
    set_rx_ready(1'b0);
    if (exp_q.size() != 0) report_error("pushed entries never reached the user side");
    // Credit reaches tx_phy two cycles after the pop
    repeat (3) @(posedge clk_wr);
    if (credits_seen() - base_credits != row_exp[cur_row]) begin
      report_mismatch("credit count", 64'(row_exp[cur_row]), 64'(credits_seen() - base_credits));
    end
  endtask

  task automatic run_b_channel();
    axi_pkt_pkg::b_pkt_t exp_q [$];
    axi_pkt_pkg::b_pkt_t pkt;
    int                  base_seen;
    int                  sent;
    int                  cycles;
    @(posedge clk_wr);
    base_seen = b_seen.size();
    sent      = 0;
    cycles    = 0;
    pkt       = rand_b();
    user_b      <= pkt;
    user_bvalid <= 1'b1;
    while (sent < row_count[cur_row] && cycles < DRAIN_CYCLES) begin
      @(negedge clk_wr);
      if (user_bready) begin
        exp_q.push_back(pkt);
        sent++;
        pkt = rand_b();
      end
      @(posedge clk_wr);
      user_b <= pkt;
      cycles++;
    end
    if (sent < row_count[cur_row]) report_error("B responses were not accepted");
    // Out of credit, the held response has to wait
    repeat (5) begin
      @(negedge clk_wr);
      if (user_bready) report_error("user_bready high with no B credit left");
      @(posedge clk_wr);
    end
    rx_phy.b_credit <= 1'b1;
    @(posedge clk_wr);
    rx_phy.b_credit <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_wr);
      cycles++;
    end while (!user_bready && cycles < 4);
    if (!user_bready) report_error("returned B credit did not raise user_bready");
    else exp_q.push_back(pkt);
    @(posedge clk_wr);
    user_bvalid <= 1'b0;
    repeat (3) @(posedge clk_wr);
    if (b_seen.size() - base_seen != row_exp[cur_row]) begin
      report_mismatch("b_push count", 64'(row_exp[cur_row]), 64'(b_seen.size() - base_seen));
    end
    for (int i = 0; i < exp_q.size() && base_seen + i < b_seen.size(); i++) begin
      if (b_seen[base_seen + i] != exp_q[i]) begin
        report_mismatch("tx_phy b", 64'(exp_q[i]), 64'(b_seen[base_seen + i]));
      end
    end
  endtask

  task automatic run_link_drop();
    link_pkg::rx_word_t rxw;
    int                 cycles;
    @(posedge clk_wr);
    rx_phy.b_credit <= 1'b1;
    @(posedge clk_wr);
    rx_phy.b_credit <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_wr);
      cycles++;
    end while (!user_bready && cycles < 4);
    if (!user_bready) report_error("user_bready did not rise before the drop");
    @(posedge clk_wr);
    rx_online <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_wr);
      cycles++;
    end while (user_bready && cycles < 2);
    if (user_bready) report_error("user_bready stayed high after rx_online dropped");
    for (int i = 0; i < row_count[cur_row] + 3; i++) begin
      rxw = '0;
      if (i < row_count[cur_row]) begin
        rxw.aw_push = 1'b1;
        rxw.aw      = rand_aw();
        rxw.w_push  = 1'b1;
        rxw.w       = rand_w();
      end
      @(posedge clk_wr);
      rx_phy       <= rxw;
      user_awready <= 1'b1;
      user_wready  <= 1'b1;
      @(negedge clk_wr);
      check_quiet("after drop");
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    rst           = 1'b1;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    init_b_credit = 8'(INIT_B_CREDIT);
    rx_phy        = '0;
    user_awready  = 1'b0;
    user_wready   = 1'b0;
    user_b        = '0;
    user_bvalid   = 1'b0;
    total_errors  = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    repeat (RESET_CYCLES) @(posedge clk_wr);
    rst <= 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_row    = r;
      row_errors = 0;
      case (row_chan[r])
        CH_IDLE: run_idle();
        CH_UP:   run_bring_up();
        CH_AW:   run_rx_channel();
        CH_W:    run_rx_channel();
        CH_B:    run_b_channel();
        default: run_link_drop();
      endcase
      if (row_errors == 0) begin
        $display("PASS %s", row_name[r]);
        tests_passed++;
      end else begin
        $display("FAIL %s with %0d errors", row_name[r], row_errors);
        tests_failed++;
      end
      total_errors += row_errors;
    end
    $display("Tests: %0d passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* axi_pkt_slave_top.f */
axi_pkt_pkg.sv
link_pkg.sv
link_online_sync.sv
ll_receive.sv
ll_transmit.sv
phy_concat.sv
axi_pkt_slave_top.sv
tb_axi_pkt_slave_props.sv
tb_axi_pkt_slave.sv

/* Makefile */
# Verilator lint and simulation for the AXI write-packet slave bridge

VERILATOR  ?= verilator
TOP        := tb_axi_pkt_slave
FILELIST   := axi_pkt_slave_top.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
SIM_LOG    := sim.log
FAIL_MSG   := Simulation failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(SIM_LOG) 2>&1; status=$$?; cat $(SIM_LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(SIM_LOG); then \
	  echo "Run failed, see $(SIM_LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
